// ==== list.f ====
+incdir+sim
source/loader_pkg.sv
source/download_decoder.sv
source/word_assembler.sv
source/write_arbiter.sv
source/loader_top.sv
sim/tb_loader.sv

// ==== sim/loader_testdata.txt ====
# test <name> | start <index> | stop | pair <main|disc> <addr> <lo> <hi> <exp addr> <exp data>
# pulses <count> | size <value> | sys|park <addr> <data> <be> | release ; numbers in hex
test bios_download
start 00
pair main 0000000 1111 2222 0200000 22221111
pair main 0000004 3333 4444 0200004 44443333
pair main 0000100 abcd 1234 0200100 1234abcd
stop
pulses 0
test exe_download
start 01
pair main 0000000 beef dead 0400000 deadbeef
pair main 0000008 5555 aaaa 0400008 aaaa5555
stop
pulses 1
test disc_download
start 42
pair disc 0000000 0f0f f0f0 0000000 f0f00f0f
pair disc 0001000 1357 2468 0001000 24681357
stop
size 0001002
pulses 0
test back_pressure
start 00
pair main 0000010 0001 0002 0200010 00020001
pair main 0000014 0003 0004 0200014 00040003
pair main 0000018 0005 0006 0200018 00060005
pair main 000001c 0007 0008 020001c 00080007
pair main 0000020 0009 000a 0200020 000a0009
pair main 0000024 000b 000c 0200024 000c000b
stop
pulses 0
test system_port
sys 0000040 cafef00d f
sys 0000044 01234567 3
start 00
pair main 0000030 aaaa bbbb 0200030 bbbbaaaa
park 0000080 55aa55aa f
pair main 0000034 cccc dddd 0200034 ddddcccc
stop
release

// ==== sim/loader_checks.svh ====
// loader testbench compare tasks
`ifndef loader_checks_svh
`define loader_checks_svh

// ========================================
// failure exit
// ========================================

// report the cause, give the verdict, stop
task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("ERRORS FOUND");
	$fatal(1, "simulation stopped at first failure");
endtask

// ========================================
// compares
// ========================================

// one memory write request, all fields at once
task automatic check_req(input string test, input string what,
		input mem_wr_req_t exp, input mem_wr_req_t act);
	string msg;
	if (act !== exp) begin
		msg = $sformatf("Error: test %s, %s, expected %b %h %h %h, actual %b %h %h %h",
			test, what, exp.valid, exp.addr, exp.data, exp.be,
			act.valid, act.addr, act.data, act.be);
		abort_run(msg);
	end
endtask

// strobes, levels and yes/no conditions
task automatic check_bit(input string test, input string what,
		input logic exp, input logic act);
	string msg;
	if (act !== exp) begin
		msg = $sformatf("Error: test %s, %s, expected %b, actual %b", test, what, exp, act);
		abort_run(msg);
	end
endtask

// captured disc size
task automatic check_size(input string test, input string what,
		input logic [29:0] exp, input logic [29:0] act);
	string msg;
	if (act !== exp) begin
		msg = $sformatf("Error: test %s, %s, expected %h, actual %h", test, what, exp, act);
		abort_run(msg);
	end
endtask

`endif

// ==== sim/tb_loader.sv ====
// loader testbench
`timescale 1ns/1ps

module tb_loader
	import loader_pkg::*;
();

	// longest single wait in cycles
	localparam int wait_limit = 200;

	logic        clk_1x = 1'b0;
	logic        rst;
	logic        download;
	logic [7:0]  index;
	host_word_t  host;
	logic        host_wait;
	mem_wr_req_t sys_req;
	logic        sys_ack;
	mem_wr_req_t main_wr;
	logic        main_ack;
	mem_wr_req_t cd_wr;
	logic        cd_ack;
	logic        load_exe;
	logic [29:0] cd_size;

	// writes seen per channel in arrival order
	mem_wr_req_t main_log[$];
	mem_wr_req_t cd_log[$];
	// system writes held back by a download
	mem_wr_req_t parked[$];

	// memory model state by slot (0 main, 1 disc)
	logic [1:0]  seen;
	logic [1:0]  ack_now;
	int          pend[2] = '{0, 0};
	int          delay[2] = '{-1, -1};
	int          acks[2] = '{0, 0};

	// strobe counters
	int          exe_pulses = 0;
	int          sys_acks = 0;
	int          main_ack_seen = 0;

	string       test_name;

	`include "loader_checks.svh"

	loader_top loader_top_i (
		.clk_1x    (clk_1x),
		.rst       (rst),
		.download  (download),
		.index     (index),
		.host      (host),
		.host_wait (host_wait),
		.sys_req   (sys_req),
		.sys_ack   (sys_ack),
		.main_wr   (main_wr),
		.main_ack  (main_ack),
		.cd_wr     (cd_wr),
		.cd_ack    (cd_ack),
		.load_exe  (load_exe),
		.cd_size   (cd_size)
	);

	// 40 ns period
	initial begin
		forever #20 clk_1x = ~clk_1x;
	end

	// ========================================
	// memory models
	// ========================================

	// log each write and ack it 0 to 5 cycles later
	initial begin : memory_models
		main_ack = 1'b0;
		cd_ack   = 1'b0;
		void'($urandom(81149));
		forever begin
			@(negedge clk_1x);
			seen = {cd_wr.valid === 1'b1, main_wr.valid === 1'b1};
			if (seen[0]) begin
				main_log.push_back(main_wr);
			end
			if (seen[1]) begin
				cd_log.push_back(cd_wr);
			end
			for (int m = 0; m < 2; m++) begin
				ack_now[m] = 1'b0;
				if (seen[m]) begin
					pend[m]++;
				end
				if (delay[m] < 0 && pend[m] > 0) begin
					delay[m] = $urandom % 6;
				end
				if (delay[m] == 0) begin
					ack_now[m] = 1'b1;
					pend[m]--;
					acks[m]++;
				end
				if (delay[m] >= 0) begin
					delay[m]--;
				end
			end
			main_ack = ack_now[0];
			cd_ack   = ack_now[1];
			if (load_exe === 1'b1) begin
				exe_pulses++;
			end
		end
	end

	// acks counted on the rising edge where they are stable
	always @(posedge clk_1x) begin
		if (sys_ack === 1'b1) begin
			sys_acks++;
		end
		if (main_ack === 1'b1) begin
			main_ack_seen++;
		end
	end

	// ========================================
	// host and system drivers
	// ========================================

	// low half and high half followed by the wait for the ack
	task automatic write_pair(input logic to_disc, input logic [mem_addr_w-1:0] addr,
			input logic [15:0] lo, input logic [15:0] hi,
			input logic [mem_addr_w-1:0] exp_addr, input logic [31:0] exp_data);
		int          acks_before;
		int          sys_before;
		int          cycles;
		mem_wr_req_t exp;
		mem_wr_req_t got;
		acks_before = to_disc ? acks[1] : acks[0];
		sys_before  = sys_acks;
		@(negedge clk_1x);
		host.wr   = 1'b1;
		host.addr = addr;
		host.data = lo;
		@(negedge clk_1x);
		host.addr = addr | 27'd2;
		host.data = hi;
		@(negedge clk_1x);
		// address stays for the disc size capture
		host.wr = 1'b0;
		check_bit(test_name, "host_wait after high half", 1'b1, host_wait);
		cycles = 0;
		while (host_wait !== 1'b0) begin
			@(negedge clk_1x);
			cycles++;
			if (cycles > wait_limit) begin
				abort_run("host_wait never fell after a host write");
			end
		end
		// released only by its own ack
		check_bit(test_name, "one ack before host_wait fell", 1'b1,
			((to_disc ? acks[1] : acks[0]) - acks_before) == 1);
		check_bit(test_name, "no sys_ack for a host write", 1'b1, sys_acks == sys_before);
		if (to_disc) begin
			check_bit(test_name, "one write on cd_wr", 1'b1, cd_log.size() == 1);
			got = cd_log.pop_front();
		end else begin
			check_bit(test_name, "one write on main_wr", 1'b1, main_log.size() == 1);
			got = main_log.pop_front();
		end
		exp.valid = 1'b1;
		exp.addr  = exp_addr;
		exp.data  = exp_data;
		exp.be    = 4'hf;
		check_req(test_name, "host write", exp, got);
		check_bit(test_name, "nothing on the other channel", 1'b1,
			(main_log.size() + cd_log.size()) == 0);
	endtask

	// one-cycle system request
	task automatic send_system_write(input mem_wr_req_t req);
		@(negedge clk_1x);
		sys_req = req;
		@(negedge clk_1x);
		sys_req.valid = 1'b0;
	endtask

	// system write on main_wr with its ack and no second copy
	task automatic take_system_write(input mem_wr_req_t exp, input int sys_start,
			input int ack_start);
		int          cycles;
		mem_wr_req_t got;
		cycles = 0;
		while (main_log.size() == 0) begin
			@(negedge clk_1x);
			cycles++;
			if (cycles > wait_limit) begin
				abort_run("system write never reached main_wr");
			end
		end
		got = main_log.pop_front();
		check_req(test_name, "system write", exp, got);
		cycles = 0;
		while (sys_acks == sys_start) begin
			@(negedge clk_1x);
			cycles++;
			if (cycles > wait_limit) begin
				abort_run("sys_ack never came back for a system write");
			end
		end
		check_bit(test_name, "sys_ack follows main_ack", 1'b1,
			(sys_acks - sys_start) == (main_ack_seen - ack_start));
		repeat (6) @(negedge clk_1x);
		check_bit(test_name, "system write delivered once", 1'b1, main_log.size() == 0);
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin : stimulus
		int               fd;
		int               code;
		int               cycles;
		int               exe_start;
		int               sys_start;
		int               ack_start;
		string            cmd;
		string            chan;
		logic [31:0]      addr;
		logic [31:0]      lo;
		logic [31:0]      hi;
		logic [31:0]      exp_addr;
		logic [31:0]      exp_data;
		logic [31:0]      be;
		logic [31:0]      num;
		logic [8*160-1:0] skip;
		mem_wr_req_t      req;
		rst       = 1'b1;
		download  = 1'b0;
		index     = 8'd0;
		host      = '0;
		sys_req   = '0;
		exe_start = 0;
		test_name = "reset";
		repeat (5) @(negedge clk_1x);
		rst = 1'b0;
		check_bit(test_name, "main_wr valid", 1'b0, main_wr.valid);
		check_bit(test_name, "cd_wr valid", 1'b0, cd_wr.valid);
		check_bit(test_name, "load_exe", 1'b0, load_exe);
		check_bit(test_name, "sys_ack", 1'b0, sys_ack);
		check_bit(test_name, "host_wait", 1'b0, host_wait);

		fd = $fopen("sim/loader_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open sim/loader_testdata.txt");
		end
		while ($fscanf(fd, "%s", cmd) == 1) begin
			case (cmd)
				"#": code = $fgets(skip, fd);
				"test": begin
					code = $fscanf(fd, "%s", test_name);
					exe_start = exe_pulses;
				end
				"start": begin
					code = $fscanf(fd, "%h", num);
					@(negedge clk_1x);
					download = 1'b1;
					index    = num[7:0];
					// mode is registered one cycle behind
					@(negedge clk_1x);
				end
				"pair": begin
					code = $fscanf(fd, "%s %h %h %h %h %h", chan, addr, lo, hi,
						exp_addr, exp_data);
					write_pair(chan == "disc", addr[26:0], lo[15:0], hi[15:0],
						exp_addr[26:0], exp_data);
				end
				"stop": begin
					@(negedge clk_1x);
					download = 1'b0;
				end
				"pulses": begin
					code = $fscanf(fd, "%h", num);
					cycles = 0;
					while ((exe_pulses - exe_start) < num) begin
						@(negedge clk_1x);
						cycles++;
						if (cycles > wait_limit) begin
							abort_run("load_exe pulse never came after the download");
						end
					end
					// room for a stray second pulse
					repeat (4) @(negedge clk_1x);
					check_bit(test_name, "load_exe pulse count", 1'b1,
						(exe_pulses - exe_start) == num);
				end
				"size": begin
					code = $fscanf(fd, "%h", num);
					cycles = 0;
					while (cd_size !== num[29:0] && cycles < 8) begin
						@(negedge clk_1x);
						cycles++;
					end
					check_size(test_name, "cd_size", num[29:0], cd_size);
				end
				"sys", "park": begin
					code = $fscanf(fd, "%h %h %h", addr, exp_data, be);
					req.valid = 1'b1;
					req.addr  = addr[26:0];
					req.data  = exp_data;
					req.be    = be[3:0];
					sys_start = sys_acks;
					ack_start = main_ack_seen;
					send_system_write(req);
					if (cmd == "park") begin
						// loader owns main so the write must wait
						repeat (3) @(negedge clk_1x);
						check_bit(test_name, "parked write held", 1'b1, main_log.size() == 0);
						parked.push_back(req);
					end else begin
						take_system_write(req, sys_start, ack_start);
					end
				end
				"release": begin
					if (parked.size() == 0) begin
						abort_run("release line without a parked system write");
					end
					sys_start = sys_acks;
					ack_start = main_ack_seen;
					take_system_write(parked.pop_front(), sys_start, ack_start);
				end
				default: abort_run($sformatf("unknown stimulus command %s", cmd));
			endcase
		end
		$fclose(fd);

		// nothing left over
		test_name = "end of run";
		check_bit(test_name, "all parked writes delivered", 1'b1, parked.size() == 0);
		check_bit(test_name, "no unchecked writes", 1'b1,
			(main_log.size() + cd_log.size()) == 0);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== source/download_decoder.sv ====
// download stream decoder
`timescale 1ns/1ps

module download_decoder
	import loader_pkg::*;
(
	input  logic                  clk_1x,
	input  logic                  rst,
	input  logic                  download,
	input  logic [7:0]            index,
	input  logic [mem_addr_w-1:0] host_addr,
	output dl_mode_t              mode,
	output logic                  load_exe,
	output logic [29:0]           cd_size
);

	// next mode from the raw host level and index
	dl_mode_t mode_d;
	// mode one cycle back, for end-of-download edges
	dl_mode_t mode_q;
	logic     exe_end;
	logic     cd_end;

	// ========================================
	// stream classification
	// ========================================

	always_comb begin
		mode_d = mode_none;
		if (download) begin
			if (index == idx_bios) begin
				mode_d = mode_bios;
			end else if (index == idx_exe) begin
				mode_d = mode_exe;
			end else if (index[5:0] == idx_cd[5:0]) begin
				// upper index bits select the disc slot, ignored here
				mode_d = mode_cd;
			end
		end
	end

	// falling edges of the registered mode
	assign exe_end = (mode_q == mode_exe) && (mode != mode_exe);
	assign cd_end  = (mode_q == mode_cd) && (mode != mode_cd);

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			mode     <= mode_none;
			mode_q   <= mode_none;
			load_exe <= 1'b0;
			cd_size  <= '0;
		end else begin
			mode     <= mode_d;
			mode_q   <= mode;
			// pulse one cycle after exe mode drops
			load_exe <= exe_end;
			// last host address is the disc length
			if (cd_end) begin
				cd_size <= {{(30-mem_addr_w){1'b0}}, host_addr};
			end
		end
	end

	// ========================================
	// checks
	// ========================================

	// system must see a single load strobe per executable
	load_exe_single: assert property (
		@(posedge clk_1x) disable iff (rst)
		load_exe |=> !load_exe
	) else $error("load_exe high on two consecutive cycles");

endmodule

// ==== source/loader_pkg.sv ====
// loader shared definitions
package loader_pkg;

	// ========================================
	// memory map
	// ========================================

	// byte address width of both memories
	localparam int mem_addr_w = 27;

	// region bases, added to the host address
	localparam logic [mem_addr_w-1:0] bios_base = 27'd2097152;
	localparam logic [mem_addr_w-1:0] exe_base  = 27'd4194304;

	// ========================================
	// host download index codes
	// ========================================

	localparam logic [7:0] idx_bios = 8'd0;
	localparam logic [7:0] idx_exe  = 8'd1;
	// only low 6 bits compared for disc images
	localparam logic [7:0] idx_cd   = 8'd2;

	// stream class seen by assembler and arbiter
	typedef enum logic [1:0] {
		mode_none,
		mode_bios,
		mode_exe,
		mode_cd
	} dl_mode_t;

	// ========================================
	// request structs
	// ========================================

	// one 32-bit memory write, valid is a single-cycle pulse
	typedef struct packed {
		logic                  valid;
		logic [mem_addr_w-1:0] addr;
		logic [31:0]           data;
		logic [3:0]            be;
	} mem_wr_req_t;

	// one 16-bit word from the host
	typedef struct packed {
		logic                  wr;
		logic [mem_addr_w-1:0] addr;
		logic [15:0]           data;
	} host_word_t;

endpackage

// ==== source/loader_top.sv ====
// memory download loader
`timescale 1ns/1ps

module loader_top
	import loader_pkg::*;
(
	input  logic        clk_1x,
	input  logic        rst,

	// host download stream
	input  logic        download,
	input  logic [7:0]  index,
	input  host_word_t  host,
	output logic        host_wait,

	// emulated system write port
	input  mem_wr_req_t sys_req,
	output logic        sys_ack,

	// main memory write channel
	output mem_wr_req_t main_wr,
	input  logic        main_ack,

	// disc memory write channel
	output mem_wr_req_t cd_wr,
	input  logic        cd_ack,

	// to the system
	output logic        load_exe,
	output logic [29:0] cd_size
);

	dl_mode_t    mode;
	mem_wr_req_t loader_req;
	logic        loader_ack;

	// ========================================
	// stream class
	// ========================================

	download_decoder download_decoder_i (
		.clk_1x    (clk_1x),
		.rst       (rst),
		.download  (download),
		.index     (index),
		.host_addr (host.addr),
		.mode      (mode),
		.load_exe  (load_exe),
		.cd_size   (cd_size)
	);

	// word pairing, picks its ack by mode
	word_assembler word_assembler_i (
		.clk_1x    (clk_1x),
		.rst       (rst),
		.mode      (mode),
		.host      (host),
		.ack       ({cd_ack, loader_ack}),
		.req       (loader_req),
		.host_wait (host_wait)
	);

	// ========================================
	// channel sharing
	// ========================================

	write_arbiter write_arbiter_i (
		.clk_1x     (clk_1x),
		.rst        (rst),
		.mode       (mode),
		.loader_req (loader_req),
		.sys_req    (sys_req),
		.main_ack   (main_ack),
		.main_wr    (main_wr),
		.cd_wr      (cd_wr),
		.loader_ack (loader_ack),
		.sys_ack    (sys_ack)
	);

endmodule

// ==== source/word_assembler.sv ====
// host word pairing
`timescale 1ns/1ps

module word_assembler
	import loader_pkg::*;
(
	input  logic        clk_1x,
	input  logic        rst,
	input  dl_mode_t    mode,
	input  host_word_t  host,
	// bit 0 main channel ack via arbiter, bit 1 disc memory ack
	input  logic [1:0]  ack,
	output mem_wr_req_t req,
	output logic        host_wait
);

	// offset added to the host address
	logic [mem_addr_w-1:0] base;
	// ack of the memory this stream targets
	logic                  ack_sel;
	logic                  active;
	logic                  wr_lo;
	logic                  wr_hi;

	// assembled write, payload only
	logic [mem_addr_w-1:0] wr_addr;
	logic [31:0]           wr_data;

	// control
	logic                  req_valid;
	logic                  wait_q;

	// ========================================
	// decode
	// ========================================

	always_comb begin
		case (mode)
			mode_bios: base = bios_base;
			mode_exe:  base = exe_base;
			default:   base = '0;
		endcase
	end

	// disc writes are acked by the second memory
	assign ack_sel = (mode == mode_cd) ? ack[1] : ack[0];

	assign active = (mode != mode_none);
	// address bit 1 picks the half of the 32-bit word
	assign wr_lo  = active && host.wr && !host.addr[1];
	assign wr_hi  = active && host.wr && host.addr[1];

	// ========================================
	// pairing
	// ========================================

	// low half carries the address
	always_ff @(posedge clk_1x) begin
		if (wr_lo) begin
			wr_data[15:0] <= host.data;
			wr_addr       <= host.addr + base;
		end
		if (wr_hi) begin
			wr_data[31:16] <= host.data;
		end
	end

	// request pulse and host wait
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			req_valid <= 1'b0;
			wait_q    <= 1'b0;
		end else begin
			req_valid <= wr_hi;
			if (!active) begin
				wait_q <= 1'b0;
			end else if (wr_hi) begin
				// raised together with the request
				wait_q <= 1'b1;
			end else if (ack_sel) begin
				wait_q <= 1'b0;
			end
		end
	end

	// ========================================
	// outputs
	// ========================================

	// always full-word writes
	assign req = '{
		valid: req_valid,
		addr:  wr_addr,
		data:  wr_data,
		be:    4'b1111
	};

	// no wait outside a download
	assign host_wait = wait_q && active;

	// ========================================
	// checks
	// ========================================

	// host has to respect the wait level
	host_holds_off: assert property (
		@(posedge clk_1x) disable iff (rst)
		host_wait |-> !host.wr
	) else $error("host write while host_wait high");

endmodule

// ==== source/write_arbiter.sv ====
// main write channel arbiter
`timescale 1ns/1ps

module write_arbiter
	import loader_pkg::*;
(
	input  logic        clk_1x,
	input  logic        rst,
	input  dl_mode_t    mode,
	input  mem_wr_req_t loader_req,
	input  mem_wr_req_t sys_req,
	input  logic        main_ack,
	output mem_wr_req_t main_wr,
	output mem_wr_req_t cd_wr,
	output logic        loader_ack,
	output logic        sys_ack
);

	// loader has the main channel
	logic        loader_owns;
	// any download keeps the system off the channel
	logic        sys_blocked;

	mem_wr_req_t main_d;
	mem_wr_req_t cd_d;
	mem_wr_req_t main_q;
	mem_wr_req_t cd_q;
	// one-deep system request parked during a download
	mem_wr_req_t hold_q;
	// owner of the last request sent on main
	logic        grant_loader;

	assign loader_owns = (mode == mode_bios) || (mode == mode_exe);
	assign sys_blocked = (mode != mode_none);

	// ========================================
	// channel select
	// ========================================

	always_comb begin
		main_d = sys_req;
		if (loader_owns) begin
			main_d = loader_req;
		end else if (sys_blocked) begin
			// disc download, nothing on main
			main_d.valid = 1'b0;
		end else if (hold_q.valid) begin
			// parked request goes first
			main_d = hold_q;
		end
	end

	// disc stream bypasses main
	always_comb begin
		cd_d       = loader_req;
		cd_d.valid = loader_req.valid && (mode == mode_cd);
	end

	// ========================================
	// registers
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			main_q.valid <= 1'b0;
			cd_q.valid   <= 1'b0;
		end else begin
			main_q <= main_d;
			cd_q   <= cd_d;
		end
	end

	// hold slot
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			hold_q.valid <= 1'b0;
		end else if (sys_blocked) begin
			if (sys_req.valid) begin
				hold_q <= sys_req;
			end
		end else if (hold_q.valid) begin
			// released this cycle, catch a new one behind it
			hold_q <= sys_req;
		end
	end

	// grant recorded at issue
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			grant_loader <= 1'b0;
		end else if (main_d.valid) begin
			grant_loader <= loader_owns;
		end
	end

	// ========================================
	// outputs
	// ========================================

	assign main_wr    = main_q;
	assign cd_wr      = cd_q;
	// ack back to whoever sent the request
	assign loader_ack = main_ack && grant_loader;
	assign sys_ack    = main_ack && !grant_loader;

	// one memory per write
	one_channel: assert property (
		@(posedge clk_1x) disable iff (rst)
		!(main_wr.valid && cd_wr.valid)
	) else $error("main_wr and cd_wr valid together");

endmodule
